// File: hw/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_lea = 4'b1110
    } lc3b_opcode;

    typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_alu_op;
    typedef enum logic [1:0] {wb_alu, wb_mem, wb_target} lc3b_wb_sel;
    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} lc3b_fwd_sel;

    // operate format, sr2 lives in imm5[2:0] when imm is clear
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    sr1;
        logic       imm;
        logic [4:0] imm5;
    } lc3b_opr_fmt;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr_sr;
        lc3b_reg    base;
        logic [5:0] offset6;
    } lc3b_mem_fmt;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_nzp    nzp;
        logic [8:0] pcoffset9;
    } lc3b_br_fmt;

    typedef union packed {
        lc3b_opr_fmt opr;
        lc3b_mem_fmt mem;
        lc3b_br_fmt  br;
    } lc3b_instr;

    typedef struct packed {
        lc3b_alu_op alu_op;
        logic       use_imm;
        // base + (offset6 << 1) for LDR/STR
        logic       use_offset6;
        logic       mem_read;
        logic       mem_write;
        logic       load_regfile;
        logic       load_cc;
        lc3b_wb_sel wb_sel;
        logic       is_br;
    } lc3b_ctrl;

    typedef struct packed {
        lc3b_ctrl   ctrl;
        lc3b_word   pc;
        lc3b_reg    src1;
        lc3b_reg    src2;
        lc3b_word   src1_data;
        lc3b_word   src2_data;
        // branch mask for BR
        lc3b_reg    dr;
        logic [8:0] low9;
    } lc3b_id_ex;

    typedef struct packed {
        lc3b_ctrl ctrl;
        lc3b_reg  dr;
        lc3b_word alu;
        lc3b_word target;
        lc3b_word store_data;
        lc3b_nzp  nzp;
    } lc3b_ex_mem;

    typedef struct packed {
        lc3b_ctrl ctrl;
        lc3b_reg  dr;
        lc3b_word alu;
        lc3b_word mem_data;
        lc3b_word target;
        lc3b_nzp  nzp;
    } lc3b_mem_wb;

    localparam lc3b_word RESET_PC = 16'h0000;

    // result an instruction writes back, also what MEM forwards to EX
    function automatic lc3b_word select_result(input lc3b_wb_sel sel, input lc3b_word alu,
                                               input lc3b_word mem, input lc3b_word target);
        case (sel)
            wb_mem:    return mem;
            wb_target: return target;
            default:   return alu;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hw/lc3b_fetch.sv
`default_nettype none
`timescale 1ns/10ps

module lc3b_fetch (
    input  wire logic                clk,
    input  wire logic                i_arst_n,
    input  wire logic                i_stall,
    input  wire logic                i_br_taken,
    input  wire lc3b_pkg::lc3b_word  i_br_target,
    input  wire lc3b_pkg::lc3b_word  i_imem_rdata,
    output lc3b_pkg::lc3b_word       o_imem_addr,
    output lc3b_pkg::lc3b_word       o_if_pc,
    output lc3b_pkg::lc3b_instr      o_if_instr
);

    lc3b_pkg::lc3b_word pc_q;
    lc3b_pkg::lc3b_word pc_plus2;

    assign pc_plus2    = pc_q + 16'd2;
    assign o_imem_addr = pc_q;

    // branch redirect wins over the load-use hold
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q <= lc3b_pkg::RESET_PC;
        end else if (i_br_taken) begin
            pc_q <= i_br_target;
        end else if (!i_stall) begin
            pc_q <= pc_plus2;
        end
    end

    // IF/ID, a zero word decodes as BR never
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_if_instr <= '0;
        end else if (i_br_taken) begin
            o_if_instr <= '0;
        end else if (!i_stall) begin
            o_if_instr <= i_imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_if_pc <= pc_plus2;
        end
    end

    // targets come from WB, so this covers the whole offset path
    a_pc_even: assert property (@(posedge clk) disable iff (!i_arst_n) !pc_q[0])
        else $error("odd PC %h", pc_q);

endmodule

`default_nettype wire

// File: hw/lc3b_decode.sv
`default_nettype none
`timescale 1ns/10ps

module lc3b_decode #(
    parameter int REG_COUNT = 8
) (
    input  wire logic                clk,
    input  wire logic                i_arst_n,
    input  wire logic                i_stall,
    input  wire logic                i_flush,
    input  wire lc3b_pkg::lc3b_word  i_if_pc,
    input  wire lc3b_pkg::lc3b_instr i_if_instr,
    input  wire logic                i_wb_we,
    input  wire lc3b_pkg::lc3b_reg   i_wb_dest,
    input  wire lc3b_pkg::lc3b_word  i_wb_data,
    output lc3b_pkg::lc3b_id_ex      o_id_ex,
    output lc3b_pkg::lc3b_reg        o_id_dest,
    output lc3b_pkg::lc3b_reg        o_id_src1,
    output lc3b_pkg::lc3b_reg        o_id_src2
);

    localparam int RA_W = $clog2(REG_COUNT);

    lc3b_pkg::lc3b_word regs [REG_COUNT];
    lc3b_pkg::lc3b_ctrl ctrl;
    lc3b_pkg::lc3b_word src1_data;
    lc3b_pkg::lc3b_word src2_data;

    always_comb begin
        ctrl = '0;
        case (i_if_instr.opr.opcode)
            lc3b_pkg::op_add, lc3b_pkg::op_and: begin
                if (i_if_instr.opr.opcode == lc3b_pkg::op_add) begin
                    ctrl.alu_op = lc3b_pkg::alu_add;
                end else begin
                    ctrl.alu_op = lc3b_pkg::alu_and;
                end
                ctrl.use_imm      = i_if_instr.opr.imm;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            lc3b_pkg::op_not: begin
                ctrl.alu_op       = lc3b_pkg::alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            lc3b_pkg::op_ldr: begin
                ctrl.use_offset6  = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.wb_sel       = lc3b_pkg::wb_mem;
            end
            lc3b_pkg::op_str: begin
                ctrl.use_offset6 = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            // LC-3b LEA leaves the condition codes alone
            lc3b_pkg::op_lea: begin
                ctrl.load_regfile = 1'b1;
                ctrl.wb_sel       = lc3b_pkg::wb_target;
            end
            lc3b_pkg::op_br: ctrl.is_br = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // sr1 and the LDR/STR base share bits 8:6
    assign o_id_src1 = i_if_instr.opr.sr1;
    assign o_id_src2 = (i_if_instr.opr.opcode == lc3b_pkg::op_str) ? i_if_instr.mem.dr_sr
                                                                  : i_if_instr.opr.imm5[2:0];
    assign o_id_dest = i_if_instr.opr.dr;

    always_ff @(posedge clk) begin
        if (i_wb_we) begin
            regs[i_wb_dest[RA_W-1:0]] <= i_wb_data;
        end
    end

    // write-through, a WB write in this cycle is seen here
    assign src1_data = (i_wb_we && i_wb_dest == o_id_src1) ? i_wb_data
                                                         : regs[o_id_src1[RA_W-1:0]];
    assign src2_data = (i_wb_we && i_wb_dest == o_id_src2) ? i_wb_data
                                                         : regs[o_id_src2[RA_W-1:0]];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex <= '0;
        end else if (i_flush || i_stall) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.ctrl      <= ctrl;
            o_id_ex.pc        <= i_if_pc;
            o_id_ex.src1      <= o_id_src1;
            o_id_ex.src2      <= o_id_src2;
            o_id_ex.src1_data <= src1_data;
            o_id_ex.src2_data <= src2_data;
            o_id_ex.dr        <= o_id_dest;
            o_id_ex.low9      <= i_if_instr.br.pcoffset9;
        end
    end

endmodule

`default_nettype wire

// File: hw/lc3b_hazard.sv
`default_nettype none
`timescale 1ns/10ps

module lc3b_hazard (
    input  wire lc3b_pkg::lc3b_reg i_ex_src1,
    input  wire lc3b_pkg::lc3b_reg i_ex_src2,
    input  wire logic              i_ex_is_load,
    input  wire lc3b_pkg::lc3b_reg i_ex_dest,
    input  wire lc3b_pkg::lc3b_reg i_id_src1,
    input  wire lc3b_pkg::lc3b_reg i_id_src2,
    input  wire lc3b_pkg::lc3b_reg i_mem_dest,
    input  wire logic              i_mem_we,
    input  wire lc3b_pkg::lc3b_reg i_wb_dest,
    input  wire logic              i_wb_we,
    output lc3b_pkg::lc3b_fwd_sel  o_fwd_a,
    output lc3b_pkg::lc3b_fwd_sel  o_fwd_b,
    output logic                   o_stall
);

    // the younger producer in MEM wins over WB
    function automatic lc3b_pkg::lc3b_fwd_sel fwd_pick(input lc3b_pkg::lc3b_reg src);
        if (i_mem_we && i_mem_dest == src) begin
            return lc3b_pkg::fwd_mem;
        end else if (i_wb_we && i_wb_dest == src) begin
            return lc3b_pkg::fwd_wb;
        end
        return lc3b_pkg::fwd_none;
    endfunction

    always_comb begin
        o_fwd_a = fwd_pick(i_ex_src1);
        o_fwd_b = fwd_pick(i_ex_src2);
        // load data only exists in MEM, one bubble covers it
        o_stall = i_ex_is_load && (i_ex_dest == i_id_src1 || i_ex_dest == i_id_src2);
    end

endmodule

`default_nettype wire

// File: hw/lc3b_execute.sv
`default_nettype none
`timescale 1ns/10ps

module lc3b_execute (
    input  wire logic                  clk,
    input  wire logic                  i_arst_n,
    input  wire logic                  i_flush,
    input  wire lc3b_pkg::lc3b_id_ex   i_id_ex,
    input  wire lc3b_pkg::lc3b_fwd_sel i_fwd_a,
    input  wire lc3b_pkg::lc3b_fwd_sel i_fwd_b,
    input  wire lc3b_pkg::lc3b_word    i_wb_fwd,
    input  wire lc3b_pkg::lc3b_word    i_dmem_rdata,
    output lc3b_pkg::lc3b_ex_mem       o_ex_mem,
    output lc3b_pkg::lc3b_word         o_dmem_addr,
    output lc3b_pkg::lc3b_word         o_dmem_wdata,
    output logic                       o_dmem_we
);

    lc3b_pkg::lc3b_word mem_fwd;
    lc3b_pkg::lc3b_word opa;
    lc3b_pkg::lc3b_word opb;
    lc3b_pkg::lc3b_word imm5_sext;
    lc3b_pkg::lc3b_word off6_adj;
    lc3b_pkg::lc3b_word off9_adj;
    lc3b_pkg::lc3b_word alu_b;
    lc3b_pkg::lc3b_word alu_out;

    function automatic lc3b_pkg::lc3b_word fwd_mux(input lc3b_pkg::lc3b_fwd_sel sel,
                                                   input lc3b_pkg::lc3b_word reg_data);
        case (sel)
            lc3b_pkg::fwd_mem: return mem_fwd;
            lc3b_pkg::fwd_wb:  return i_wb_fwd;
            default:           return reg_data;
        endcase
    endfunction

    // load data arrives combinationally while the LDR sits in MEM
    assign mem_fwd = lc3b_pkg::select_result(o_ex_mem.ctrl.wb_sel, o_ex_mem.alu,
                                             i_dmem_rdata, o_ex_mem.target);

    always_comb begin
        opa = fwd_mux(i_fwd_a, i_id_ex.src1_data);
        opb = fwd_mux(i_fwd_b, i_id_ex.src2_data);
    end

    assign imm5_sext = {{11{i_id_ex.low9[4]}}, i_id_ex.low9[4:0]};
    assign off6_adj  = {{9{i_id_ex.low9[5]}}, i_id_ex.low9[5:0], 1'b0};
    assign off9_adj  = {{6{i_id_ex.low9[8]}}, i_id_ex.low9, 1'b0};

    assign alu_b = i_id_ex.ctrl.use_imm     ? imm5_sext :
                   i_id_ex.ctrl.use_offset6 ? off6_adj  : opb;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            lc3b_pkg::alu_add: alu_out = opa + alu_b;
            lc3b_pkg::alu_and: alu_out = opa & alu_b;
            lc3b_pkg::alu_not: alu_out = ~opa;
            default:           alu_out = alu_b;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ex_mem <= '0;
        end else if (i_flush) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.ctrl       <= i_id_ex.ctrl;
            o_ex_mem.dr         <= i_id_ex.dr;
            o_ex_mem.alu        <= alu_out;
            // pc here is already pc+2
            o_ex_mem.target     <= i_id_ex.pc + off9_adj;
            o_ex_mem.store_data <= opb;
            o_ex_mem.nzp        <= i_id_ex.dr;
        end
    end

    assign o_dmem_addr  = o_ex_mem.alu;
    assign o_dmem_wdata = o_ex_mem.store_data;
    // a store in the shadow of a taken branch must not land
    assign o_dmem_we    = o_ex_mem.ctrl.mem_write & ~i_flush;

endmodule

`default_nettype wire

// File: hw/lc3b_writeback.sv
`default_nettype none
`timescale 1ns/10ps

module lc3b_writeback (
    input  wire logic                 clk,
    input  wire logic                 i_arst_n,
    input  wire lc3b_pkg::lc3b_ex_mem i_ex_mem,
    input  wire lc3b_pkg::lc3b_word   i_dmem_rdata,
    output logic                      o_wb_we,
    output lc3b_pkg::lc3b_reg         o_wb_dest,
    output lc3b_pkg::lc3b_word        o_wb_data,
    output logic                      o_br_taken,
    output lc3b_pkg::lc3b_word        o_br_target
);

    lc3b_pkg::lc3b_mem_wb mem_wb_q;
    lc3b_pkg::lc3b_nzp    cc_q;
    lc3b_pkg::lc3b_nzp    new_cc;

    // the instruction leaving MEM is the fourth squashed slot
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_wb_q <= '0;
        end else if (o_br_taken) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.ctrl     <= i_ex_mem.ctrl;
            mem_wb_q.dr       <= i_ex_mem.dr;
            mem_wb_q.alu      <= i_ex_mem.alu;
            mem_wb_q.mem_data <= i_dmem_rdata;
            mem_wb_q.target   <= i_ex_mem.target;
            mem_wb_q.nzp      <= i_ex_mem.nzp;
        end
    end

    assign o_wb_data = lc3b_pkg::select_result(mem_wb_q.ctrl.wb_sel, mem_wb_q.alu,
                                               mem_wb_q.mem_data, mem_wb_q.target);
    assign o_wb_we   = mem_wb_q.ctrl.load_regfile;
    assign o_wb_dest = mem_wb_q.dr;

    always_comb begin
        if (o_wb_data[15]) begin
            new_cc = 3'b100;
        end else if (o_wb_data == '0) begin
            new_cc = 3'b010;
        end else begin
            new_cc = 3'b001;
        end
    end

    // starts at z so BRnzp is taken even before the first cc write
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cc_q <= 3'b010;
        end else if (mem_wb_q.ctrl.load_cc) begin
            cc_q <= new_cc;
        end
    end

    assign o_br_taken  = mem_wb_q.ctrl.is_br && |(cc_q & mem_wb_q.nzp);
    assign o_br_target = mem_wb_q.target;

    // the nzp mask rides in dr, so a branch must never write a register
    a_br_no_write: assert property (@(posedge clk) disable iff (!i_arst_n)
                                    mem_wb_q.ctrl.is_br |-> !o_wb_we)
        else $error("branch writes register %0d", o_wb_dest);

endmodule

`default_nettype wire

// File: hw/lc3b_pipeline.sv
`default_nettype none
`timescale 1ns/10ps

module lc3b_pipeline #(
    parameter int REG_COUNT = 8
) (
    input  wire logic               clk,
    input  wire logic               i_arst_n,
    output lc3b_pkg::lc3b_word      o_imem_addr,
    input  wire lc3b_pkg::lc3b_word i_imem_rdata,
    output lc3b_pkg::lc3b_word      o_dmem_addr,
    output lc3b_pkg::lc3b_word      o_dmem_wdata,
    output logic                    o_dmem_we,
    input  wire lc3b_pkg::lc3b_word i_dmem_rdata
);

    logic                  stall;
    logic                  br_taken;
    lc3b_pkg::lc3b_word    br_target;
    lc3b_pkg::lc3b_word    if_pc;
    lc3b_pkg::lc3b_instr   if_instr;
    lc3b_pkg::lc3b_reg     id_src1;
    lc3b_pkg::lc3b_reg     id_src2;
    lc3b_pkg::lc3b_id_ex   id_ex;
    lc3b_pkg::lc3b_ex_mem  ex_mem;
    lc3b_pkg::lc3b_fwd_sel fwd_a;
    lc3b_pkg::lc3b_fwd_sel fwd_b;
    logic                  wb_we;
    lc3b_pkg::lc3b_reg     wb_dest;
    lc3b_pkg::lc3b_word    wb_data;

    lc3b_fetch fetch_inst (
        .clk, .i_arst_n, .i_stall(stall), .i_br_taken(br_taken), .i_br_target(br_target),
        .i_imem_rdata, .o_imem_addr, .o_if_pc(if_pc), .o_if_instr(if_instr)
    );

    lc3b_decode #(.REG_COUNT(REG_COUNT)) decode_inst (
        .clk, .i_arst_n, .i_stall(stall), .i_flush(br_taken),
        .i_if_pc(if_pc), .i_if_instr(if_instr),
        .i_wb_we(wb_we), .i_wb_dest(wb_dest), .i_wb_data(wb_data),
        .o_id_ex(id_ex), .o_id_dest(), .o_id_src1(id_src1), .o_id_src2(id_src2)
    );

    lc3b_hazard hazard_inst (
        .i_ex_src1(id_ex.src1), .i_ex_src2(id_ex.src2),
        .i_ex_is_load(id_ex.ctrl.mem_read), .i_ex_dest(id_ex.dr),
        .i_id_src1(id_src1), .i_id_src2(id_src2),
        .i_mem_dest(ex_mem.dr), .i_mem_we(ex_mem.ctrl.load_regfile),
        .i_wb_dest(wb_dest), .i_wb_we(wb_we),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_stall(stall)
    );

    lc3b_execute execute_inst (
        .clk, .i_arst_n, .i_flush(br_taken), .i_id_ex(id_ex),
        .i_fwd_a(fwd_a), .i_fwd_b(fwd_b), .i_wb_fwd(wb_data), .i_dmem_rdata,
        .o_ex_mem(ex_mem), .o_dmem_addr, .o_dmem_wdata, .o_dmem_we
    );

    lc3b_writeback writeback_inst (
        .clk, .i_arst_n, .i_ex_mem(ex_mem), .i_dmem_rdata,
        .o_wb_we(wb_we), .o_wb_dest(wb_dest), .o_wb_data(wb_data),
        .o_br_taken(br_taken), .o_br_target(br_target)
    );

endmodule

`default_nettype wire

// File: sim/tb_lc3b_pipeline.sv
`default_nettype none
`timescale 1ns/10ps

module tb_lc3b_pipeline;

    localparam int REG_COUNT    = 8;
    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_CYCLES   = 60;
    localparam int NUM_TESTS    = 5;
    // one edge to enter reset, then reset and run
    localparam int TEST_CYCLES  = 1 + RESET_CYCLES + RUN_CYCLES;
    localparam int MAX_CYCLES   = NUM_TESTS * TEST_CYCLES + 215;

    logic        clk;
    logic        arst_n;
    logic [15:0] imem_addr;
    logic [15:0] imem_rdata;
    logic [15:0] dmem_addr;
    logic [15:0] dmem_wdata;
    logic [15:0] dmem_rdata;
    logic        dmem_we;

    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] wlog_addr [$];
    logic [15:0] wlog_data [$];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic [7:0]  preload_index;
    logic [15:0] preload_data;
    int          prog_len;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          cycle_count = 0;
    integer      seed;

    lc3b_pipeline #(.REG_COUNT(REG_COUNT)) lc3b_pipeline_inst (
        .clk          (clk),
        .i_arst_n     (arst_n),
        .o_imem_addr  (imem_addr),
        .i_imem_rdata (imem_rdata),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_we    (dmem_we),
        .i_dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // word addressed, both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[8:1]];
    assign dmem_rdata = dmem[dmem_addr[8:1]];

    // held in reset, the data memory clears and keeps only the preload word
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i[7:0]] = 16'h0000;
            end
            dmem[preload_index] = preload_data;
            wlog_addr.delete();
            wlog_data.delete();
        end else if (dmem_we) begin
            dmem[dmem_addr[8:1]] = dmem_wdata;
            wlog_addr.push_back(dmem_addr);
            wlog_data.push_back(dmem_wdata);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] add_imm(input logic [2:0] dr, input logic [2:0] sr1,
                                            input logic [4:0] imm);
        return {4'b0001, dr, sr1, 1'b1, imm};
    endfunction

    function automatic logic [15:0] add_reg(input logic [2:0] dr, input logic [2:0] sr1,
                                            input logic [2:0] sr2);
        return {4'b0001, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic logic [15:0] and_imm(input logic [2:0] dr, input logic [2:0] sr1,
                                            input logic [4:0] imm);
        return {4'b0101, dr, sr1, 1'b1, imm};
    endfunction

    function automatic logic [15:0] and_reg(input logic [2:0] dr, input logic [2:0] sr1,
                                            input logic [2:0] sr2);
        return {4'b0101, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic logic [15:0] not_of(input logic [2:0] dr, input logic [2:0] sr);
        return {4'b1001, dr, sr, 6'b111111};
    endfunction

    function automatic logic [15:0] load_word(input logic [2:0] dr, input logic [2:0] base,
                                              input logic [5:0] off6);
        return {4'b0110, dr, base, off6};
    endfunction

    function automatic logic [15:0] store_word(input logic [2:0] sr, input logic [2:0] base,
                                               input logic [5:0] off6);
        return {4'b0111, sr, base, off6};
    endfunction

    function automatic logic [15:0] lea_of(input logic [2:0] dr, input logic [8:0] off9);
        return {4'b1110, dr, off9};
    endfunction

    function automatic logic [15:0] branch(input logic [2:0] nzp, input logic [8:0] off9);
        return {4'b0000, nzp, off9};
    endfunction

    function automatic logic [15:0] sext5(input logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    function automatic logic [15:0] sext9(input logic [8:0] v);
        return {{7{v[8]}}, v};
    endfunction

    function automatic logic [15:0] pc_of(input int index);
        return lc3b_pkg::RESET_PC + 16'(2 * index);
    endfunction

    task automatic emit(input logic [15:0] word);
        imem[prog_len[7:0]] = word;
        prog_len++;
    endtask

    task automatic expect_write(input logic [15:0] addr, input logic [15:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic start_test();
        @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = 16'h0000;
        end
        preload_index = 8'h00;
        preload_data  = 16'h0000;
        exp_addr.delete();
        exp_data.delete();
        prog_len = 0;
    endtask

    task automatic finish_test(input string name);
        int errors_before;
        int n;
        errors_before = error_count;
        // program parks on a branch to itself
        emit(branch(3'b111, 9'h1ff));
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        repeat (RUN_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        if (wlog_addr.size() != exp_addr.size()) begin
            $display("%s: expected %0d data memory writes but saw %0d",
                     name, exp_addr.size(), wlog_addr.size());
            error_count++;
        end
        n = (wlog_addr.size() < exp_addr.size()) ? wlog_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            if (wlog_addr[i] !== exp_addr[i]) begin
                $display("[FAIL] %s write %0d address: expected %h, actual %h",
                         name, i, exp_addr[i], wlog_addr[i]);
                error_count++;
            end
            if (wlog_data[i] !== exp_data[i]) begin
                $display("[FAIL] %s write %0d data: expected %h, actual %h",
                         name, i, exp_data[i], wlog_data[i]);
                error_count++;
            end
        end
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // each result feeds the next, so MEM and WB forwarding both get used
    task automatic dependent_alu_test();
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] v3;
        logic [15:0] v4;
        logic [15:0] v5;
        start_test();
        emit(and_imm(3'd0, 3'd0, 5'd0));
        emit(and_imm(3'd1, 3'd1, 5'd0));
        emit(add_imm(3'd1, 3'd1, 5'd7));
        emit(add_imm(3'd2, 3'd1, 5'(-3)));
        emit(and_reg(3'd3, 3'd2, 3'd1));
        emit(not_of(3'd4, 3'd3));
        emit(add_reg(3'd5, 3'd4, 3'd2));
        emit(store_word(3'd5, 3'd0, 6'd1));
        emit(store_word(3'd4, 3'd0, 6'd2));
        emit(store_word(3'd3, 3'd0, 6'd3));
        v1 = 16'd0 + sext5(5'd7);
        v2 = v1 + sext5(5'(-3));
        v3 = v2 & v1;
        v4 = ~v3;
        v5 = v4 + v2;
        expect_write(16'd2, v5);
        expect_write(16'd4, v4);
        expect_write(16'd6, v3);
        finish_test("dependent_alu");
    endtask

    task automatic load_use_test();
        start_test();
        preload_index = 8'd8;
        preload_data  = 16'h1234;
        emit(and_imm(3'd0, 3'd0, 5'd0));
        emit(load_word(3'd1, 3'd0, 6'd8));
        emit(add_imm(3'd2, 3'd1, 5'd5));
        emit(store_word(3'd2, 3'd0, 6'd10));
        // load data straight into store data
        emit(load_word(3'd3, 3'd0, 6'd8));
        emit(store_word(3'd3, 3'd0, 6'd11));
        expect_write(16'd20, 16'h1234 + sext5(5'd5));
        expect_write(16'd22, 16'h1234);
        finish_test("load_use");
    endtask

    // odd stores land, the ones right after a taken branch are skipped
    task automatic branch_test();
        start_test();
        emit(and_imm(3'd0, 3'd0, 5'd0));
        emit(add_imm(3'd1, 3'd0, 5'(-2)));
        emit(branch(3'b011, 9'd1));
        emit(store_word(3'd1, 3'd0, 6'd1));
        emit(branch(3'b100, 9'd1));
        emit(store_word(3'd1, 3'd0, 6'd2));
        emit(add_imm(3'd1, 3'd0, 5'd0));
        emit(branch(3'b101, 9'd1));
        emit(store_word(3'd1, 3'd0, 6'd3));
        emit(branch(3'b010, 9'd1));
        emit(store_word(3'd1, 3'd0, 6'd4));
        emit(add_imm(3'd1, 3'd0, 5'd9));
        emit(branch(3'b110, 9'd1));
        emit(store_word(3'd1, 3'd0, 6'd5));
        emit(branch(3'b001, 9'd1));
        emit(store_word(3'd1, 3'd0, 6'd6));
        emit(store_word(3'd1, 3'd0, 6'd7));
        expect_write(16'd2, 16'd0 + sext5(5'(-2)));
        expect_write(16'd6, 16'd0);
        expect_write(16'd10, 16'd0 + sext5(5'd9));
        expect_write(16'd14, 16'd0 + sext5(5'd9));
        finish_test("branch");
    endtask

    task automatic lea_store_test();
        logic [15:0] lea1;
        logic [15:0] lea2;
        logic [15:0] sum;
        start_test();
        emit(and_imm(3'd0, 3'd0, 5'd0));
        emit(lea_of(3'd1, 9'd5));
        emit(store_word(3'd1, 3'd0, 6'd1));
        emit(lea_of(3'd2, 9'(-3)));
        emit(add_imm(3'd3, 3'd0, 5'd11));
        emit(store_word(3'd3, 3'd0, 6'd2));
        emit(store_word(3'd2, 3'd0, 6'd3));
        emit(add_reg(3'd3, 3'd3, 3'd1));
        emit(store_word(3'd3, 3'd0, 6'd4));
        lea1 = pc_of(1) + 16'd2 + (sext9(9'd5) << 1);
        lea2 = pc_of(3) + 16'd2 + (sext9(9'(-3)) << 1);
        sum  = 16'd0 + sext5(5'd11);
        expect_write(16'd2, lea1);
        expect_write(16'd4, sum);
        expect_write(16'd6, lea2);
        expect_write(16'd8, sum + lea1);
        finish_test("lea_store");
    endtask

    task automatic random_imm_test();
        logic [4:0]  imm;
        logic [15:0] acc;
        start_test();
        emit(and_imm(3'd0, 3'd0, 5'd0));
        emit(and_imm(3'd1, 3'd1, 5'd0));
        acc = 16'd0;
        for (int k = 0; k < 5; k++) begin
            imm = 5'($random(seed));
            emit(add_imm(3'd1, 3'd1, imm));
            emit(store_word(3'd1, 3'd0, 6'(k + 1)));
            acc = acc + sext5(imm);
            expect_write(16'((k + 1) * 2), acc);
        end
        finish_test("random_imm");
    endtask

    initial begin
        arst_n        = 1'b0;
        preload_index = 8'h00;
        preload_data  = 16'h0000;
        prog_len      = 0;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        seed          = 32'ha8a3;
        dependent_alu_test();
        load_use_test();
        branch_test();
        lea_store_test();
        random_imm_test();
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/lc3b_pkg.sv
hw/lc3b_fetch.sv
hw/lc3b_decode.sv
hw/lc3b_hazard.sv
hw/lc3b_execute.sv
hw/lc3b_writeback.sv
hw/lc3b_pipeline.sv
sim/tb_lc3b_pipeline.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_lc3b_pipeline -f files.f -o tb_lc3b_pipeline &&
./obj_dir/tb_lc3b_pipeline | tee /dev/stderr | grep "Test OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
